// ==== hw/sifhPkg.sv ====
`default_nettype none

package sifhPkg;

    // histogram builder states
    // stAcq counts strobes into the bins
    // stScan streams one bin per cycle to the peak detector
    // stClear zeroes every bin and flips the pass
    typedef enum logic [1:0] {
        stAcq,
        stScan,
        stClear
    } histStateT;

    // which histogram is being built
    // coarse covers the full sample range
    // fine covers the two-bin window around the coarse peak
    typedef enum logic {
        passCoarse,
        passFine
    } passT;

endpackage : sifhPkg

`default_nettype wire

// ==== hw/dataFilter.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataFilter #(
    parameter int np     = 8,
    parameter int nbLog2 = 4
) (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic [np-1:0]     sample,
    input  wire logic              wrEn,
    input  wire sifhPkg::passT     hisNum,
    input  wire logic [nbLog2-1:0] peakCoarse,
    input  wire logic              coarseDone,
    output logic                   sampleStrobe,
    output logic [nbLog2-1:0]      binAddr,
    output logic                   inWindow,
    output logic [np-1:0]          windowLow
);
    import sifhPkg::*;

    // coarse bin width is 2^cwLog2 codes
    localparam int cwLog2 = np - nbLog2;
    localparam int cw     = 2 ** cwLog2;
    localparam int halfCw = cw / 2;
    localparam int twoCw  = 2 * cw;
    // highest window start that still fits in the code range
    localparam int maxLow = 2 ** np - twoCw;
    // offset bits that span the fine window
    localparam int offW   = cwLog2 + 1;

    logic [np-1:0] offset;
    logic          fineHit;
    logic [np-1:0] binLow;

    always_comb begin
        offset  = sample - windowLow;
        // inside [windowLow, windowLow + 2cw)
        fineHit = (sample >= windowLow) && (offset < twoCw);
        // low edge of the winning coarse bin
        binLow  = {peakCoarse, {cwLog2{1'b0}}};
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sampleStrobe <= 1'b0;
        end else begin
            sampleStrobe <= wrEn;
        end
    end

    // coarse bin is the sample MSBs, fine bin the window offset MSBs
    always_ff @(posedge clk) begin
        if (hisNum == passCoarse) begin
            binAddr  <= sample[np-1 -: nbLog2];
            inWindow <= 1'b1;
        end else begin
            binAddr  <= offset[offW-1 -: nbLog2];
            inWindow <= fineHit;
        end
    end

    // window centred on the coarse peak, clamped at both ends
    always_ff @(posedge clk) begin
        if (!rstN) begin
            windowLow <= '0;
        end else if (coarseDone) begin
            if (binLow < halfCw) begin
                windowLow <= '0;
            end else if (binLow - halfCw > maxLow) begin
                windowLow <= np'(maxLow);
            end else begin
                windowLow <= binLow - np'(halfCw);
            end
        end
    end

endmodule : dataFilter

`default_nettype wire

// ==== hw/histBuilder.sv ====
`timescale 1ns/1ps
`default_nettype none

module histBuilder #(
    parameter int nbLog2     = 4,
    parameter int acqLen     = 8,
    parameter int countWidth = 4
) (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              sampleStrobe,
    input  wire logic [nbLog2-1:0] binAddr,
    input  wire logic              inWindow,
    output logic                   acqReady,
    output sifhPkg::passT          hisNum,
    output logic                   binValid,
    output logic [nbLog2-1:0]      binIdx,
    output logic [countWidth-1:0]  binCount,
    output logic                   scanLast
);
    import sifhPkg::*;

    localparam int nBins = 2 ** nbLog2;
    localparam int seenW = $clog2(acqLen + 1);

    histStateT             state;
    logic [countWidth-1:0] binCnt [nBins];
    // strobes accepted in this pass, in window or not
    logic [seenW-1:0]      seenCount;
    logic [nbLog2-1:0]     scanIdx;
    // acqReady as seen when the filter sampled wrEn
    logic                  readyDly;
    logic                  takeSample;
    logic                  lastSample;

    always_comb begin
        // strobe only counts if it was offered while ready
        takeSample = sampleStrobe && readyDly && (state == stAcq);
        lastSample = takeSample && (seenCount == seenW'(acqLen - 1));
        // drop ready early on the final sample so no strobe slips in
        acqReady   = (state == stAcq) && !lastSample;
        binValid   = (state == stScan);
        binIdx     = scanIdx;
        binCount   = binCnt[scanIdx];
        scanLast   = binValid && (scanIdx == '1);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= stAcq;
            hisNum    <= passCoarse;
            seenCount <= '0;
            scanIdx   <= '0;
            readyDly  <= 1'b0;
            for (int i = 0; i < nBins; i++) begin
                binCnt[i] <= '0;
            end
        end else begin
            readyDly <= acqReady;
            case (state)
                stAcq: begin
                    if (takeSample) begin
                        seenCount <= seenCount + 1'b1;
                        // out-of-window fine samples only bump the count
                        if (inWindow) begin
                            binCnt[binAddr] <= binCnt[binAddr] + 1'b1;
                        end
                    end
                    if (lastSample) begin
                        state   <= stScan;
                        scanIdx <= '0;
                    end
                end
                stScan: begin
                    // bins go out in index order, 0 first
                    scanIdx <= scanIdx + 1'b1;
                    if (scanLast) begin
                        state <= stClear;
                    end
                end
                default: begin
                    // single clear cycle then swap passes
                    for (int i = 0; i < nBins; i++) begin
                        binCnt[i] <= '0;
                    end
                    seenCount <= '0;
                    hisNum    <= (hisNum == passCoarse) ? passFine : passCoarse;
                    state     <= stAcq;
                end
            endcase
        end
    end

endmodule : histBuilder

`default_nettype wire

// ==== hw/peakDetector.sv ====
`timescale 1ns/1ps
`default_nettype none

module peakDetector #(
    parameter int nbLog2     = 4,
    parameter int countWidth = 4
) (
    input  wire logic                  clk,
    input  wire logic                  rstN,
    input  wire logic                  binValid,
    input  wire logic [nbLog2-1:0]     binIdx,
    input  wire logic [countWidth-1:0] binCount,
    input  wire logic                  scanLast,
    input  wire sifhPkg::passT         hisNum,
    output logic [nbLog2-1:0]          peakCoarse,
    output logic [nbLog2-1:0]          peakFine,
    output logic                       coarseDone,
    output logic                       resultValid
);
    import sifhPkg::*;

    // running maximum over the current scan
    logic [countWidth-1:0] maxCount;
    logic [nbLog2-1:0]     maxIdx;
    logic                  takeBin;
    logic [nbLog2-1:0]     bestIdx;

    always_comb begin
        // bin 0 restarts the search, strict compare keeps the lowest index
        takeBin = (binIdx == '0) || (binCount > maxCount);
        bestIdx = takeBin ? binIdx : maxIdx;
    end

    always_ff @(posedge clk) begin
        if (binValid && takeBin) begin
            maxCount <= binCount;
            maxIdx   <= binIdx;
        end
    end

    // result lands one cycle after scanLast
    always_ff @(posedge clk) begin
        if (!rstN) begin
            peakCoarse  <= '0;
            peakFine    <= '0;
            coarseDone  <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            coarseDone  <= 1'b0;
            resultValid <= 1'b0;
            if (scanLast) begin
                if (hisNum == passCoarse) begin
                    peakCoarse <= bestIdx;
                    coarseDone <= 1'b1;
                end else begin
                    peakFine    <= bestIdx;
                    resultValid <= 1'b1;
                end
            end
        end
    end

endmodule : peakDetector

`default_nettype wire

// ==== hw/sifhTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhTop #(
    parameter int np         = 8,
    parameter int nbLog2     = 4,
    parameter int acqLen     = 8,
    parameter int countWidth = 4
) (
    input  wire logic         clk,
    input  wire logic         rstN,
    input  wire logic [np-1:0] sample,
    input  wire logic         wrEn,
    output logic              acqReady,
    output logic [nbLog2-1:0] peakCoarse,
    output logic [nbLog2-1:0] peakFine,
    output logic [np-1:0]     windowLow,
    output logic              resultValid
);
    import sifhPkg::*;

    // pass flag shared by all three blocks
    passT                  hisNum;
    // filter to builder
    logic                  sampleStrobe;
    logic [nbLog2-1:0]     binAddr;
    logic                  inWindow;
    // builder scan stream
    logic                  binValid;
    logic [nbLog2-1:0]     binIdx;
    logic [countWidth-1:0] binCount;
    logic                  scanLast;
    // coarse peak ready, loads the window
    logic                  coarseDone;

    dataFilter #(
        .np     (np),
        .nbLog2 (nbLog2)
    ) filter0 (
        .clk          (clk),
        .rstN         (rstN),
        .sample       (sample),
        .wrEn         (wrEn),
        .hisNum       (hisNum),
        .peakCoarse   (peakCoarse),
        .coarseDone   (coarseDone),
        .sampleStrobe (sampleStrobe),
        .binAddr      (binAddr),
        .inWindow     (inWindow),
        .windowLow    (windowLow)
    );

    histBuilder #(
        .nbLog2     (nbLog2),
        .acqLen     (acqLen),
        .countWidth (countWidth)
    ) builder0 (
        .clk          (clk),
        .rstN         (rstN),
        .sampleStrobe (sampleStrobe),
        .binAddr      (binAddr),
        .inWindow     (inWindow),
        .acqReady     (acqReady),
        .hisNum       (hisNum),
        .binValid     (binValid),
        .binIdx       (binIdx),
        .binCount     (binCount),
        .scanLast     (scanLast)
    );

    peakDetector #(
        .nbLog2     (nbLog2),
        .countWidth (countWidth)
    ) peak0 (
        .clk         (clk),
        .rstN        (rstN),
        .binValid    (binValid),
        .binIdx      (binIdx),
        .binCount    (binCount),
        .scanLast    (scanLast),
        .hisNum      (hisNum),
        .peakCoarse  (peakCoarse),
        .peakFine    (peakFine),
        .coarseDone  (coarseDone),
        .resultValid (resultValid)
    );

endmodule : sifhTop

`default_nettype wire

// ==== test/sifhClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhClockGen #(
    parameter real periodNs    = 4.0,
    parameter int  resetCycles = 2
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2.0) clk = ~clk;
    end

    // reset is released on a rising edge, like any other input
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule : sifhClockGen

`default_nettype wire

// ==== test/sifhTop_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhTopChecks #(
    parameter int np     = 8,
    parameter int nbLog2 = 4
) (
    input wire logic          clk,
    input wire logic          rstN,
    input wire logic          acqReady,
    input wire logic          resultValid,
    input wire logic [np-1:0] windowLow
);
    // coarse bin width and highest legal window start
    localparam int cw     = 2 ** (np - nbLog2);
    localparam int maxLow = 2 ** np - 2 * cw;

    // failures so far, read by the testbench at the end
    int fails = 0;

    // result strobe is a single-cycle pulse
    resultPulse: assert property (
        @(posedge clk) disable iff (!rstN) resultValid |=> !resultValid
    ) else begin
        $error("resultValid high on two consecutive cycles");
        fails++;
    end

    // builder is clearing while the result is out, then accepts again
    readyAfterResult: assert property (
        @(posedge clk) disable iff (!rstN) resultValid |-> !acqReady ##1 acqReady
    ) else begin
        $error("acqReady wrong around resultValid");
        fails++;
    end

    // window must always fit in the code range
    windowInRange: assert property (
        @(posedge clk) disable iff (!rstN) windowLow <= maxLow
    ) else begin
        $error("windowLow above the clamp limit");
        fails++;
    end

endmodule : sifhTopChecks

`default_nettype wire

// ==== test/sifhTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhTb;

    // must match the DUT defaults
    localparam int np            = 8;
    localparam int nbLog2        = 4;
    localparam int acqLen        = 8;
    localparam int nBins         = 2 ** nbLog2;
    localparam int cwLog2        = np - nbLog2;
    localparam int cw            = 2 ** cwLog2;
    // fine window is two coarse bins split into nBins
    localparam int fineW         = 2 * cw / nBins;
    localparam int maxLow        = 2 ** np - 2 * cw;
    localparam int timeoutCycles = 200;
    localparam logic [31:0] lfsrSeed = 32'd82720;
    localparam string traceFile  = "test/sifhTrace.txt";

    logic              clk;
    logic              rstN;
    logic [np-1:0]     sample;
    logic              wrEn;
    logic              acqReady;
    logic [nbLog2-1:0] peakCoarse;
    logic [nbLog2-1:0] peakFine;
    logic [np-1:0]     windowLow;
    logic              resultValid;

    logic [31:0]   lfsrState;
    logic [np-1:0] coarseSamples [acqLen];
    logic [np-1:0] fineSamples [acqLen];
    int            valueErrors;
    int            traceErrors;
    int            timeouts;
    bit            aborted;

    sifhClockGen #(
        .periodNs    (4.0),
        .resetCycles (2)
    ) clockGen0 (
        .clk  (clk),
        .rstN (rstN)
    );

    sifhTop dut0 (
        .clk         (clk),
        .rstN        (rstN),
        .sample      (sample),
        .wrEn        (wrEn),
        .acqReady    (acqReady),
        .peakCoarse  (peakCoarse),
        .peakFine    (peakFine),
        .windowLow   (windowLow),
        .resultValid (resultValid)
    );

    bind sifhTop sifhTopChecks #(
        .np     (np),
        .nbLog2 (nbLog2)
    ) checks0 (
        .clk         (clk),
        .rstN        (rstN),
        .acqReady    (acqReady),
        .resultValid (resultValid),
        .windowLow   (windowLow)
    );

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic drawBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsrState[0]);
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    // lowest index wins on equal counts
    function automatic int fullestBin(input int counts [nBins]);
        int best;
        best = 0;
        for (int i = 1; i < nBins; i++) begin
            if (counts[i] > counts[best]) begin
                best = i;
            end
        end
        return best;
    endfunction

    // expected results straight from the binning rules
    task automatic predict(output int pc, output int wl, output int pf);
        int counts [nBins];
        int offset;
        for (int i = 0; i < nBins; i++) begin
            counts[i] = 0;
        end
        foreach (coarseSamples[i]) begin
            counts[int'(coarseSamples[i]) >> cwLog2]++;
        end
        pc = fullestBin(counts);
        // centre two coarse bins on the peak, then clamp
        wl = pc * cw - cw / 2;
        if (wl < 0) begin
            wl = 0;
        end else if (wl > maxLow) begin
            wl = maxLow;
        end
        for (int i = 0; i < nBins; i++) begin
            counts[i] = 0;
        end
        foreach (fineSamples[i]) begin
            offset = int'(fineSamples[i]) - wl;
            // out-of-window samples are not binned
            if (offset >= 0 && offset < 2 * cw) begin
                counts[offset / fineW]++;
            end
        end
        pf = fullestBin(counts);
    endtask

    task automatic reportWrong(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        $display("CHECK FAILED %s %s: expected %0h, actual %0h", test, field, expected, actual);
        valueErrors++;
    endtask

    task automatic waitReset();
        int n;
        n = 0;
        @(negedge clk);
        while (rstN !== 1'b1) begin
            if (n == timeoutCycles) begin
                $display("timeout: reset was never released");
                timeouts++;
                aborted = 1'b1;
                return;
            end
            @(negedge clk);
            n++;
        end
    endtask

    // returns at a falling edge with acqReady at the wanted level
    task automatic waitReady(input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (acqReady !== level) begin
            if (n == timeoutCycles) begin
                $display("timeout: acqReady never went %0b during %s", level, what);
                timeouts++;
                aborted = 1'b1;
                return;
            end
            @(posedge clk);
            wrEn <= 1'b0;
            @(negedge clk);
            n++;
        end
    endtask

    task automatic waitResult(input string test);
        int n;
        n = 0;
        @(negedge clk);
        while (resultValid !== 1'b1) begin
            if (n == timeoutCycles) begin
                $display("timeout: resultValid never came for %s", test);
                timeouts++;
                aborted = 1'b1;
                return;
            end
            @(negedge clk);
            n++;
        end
    endtask

    // strobe held for one cycle, then 0 to 3 idle cycles
    task automatic sendSample(input logic [np-1:0] value, input string test);
        int gap;
        waitReady(1'b1, test);
        if (aborted) begin
            return;
        end
        @(posedge clk);
        sample <= value;
        wrEn   <= 1'b1;
        drawBits(2, gap);
        repeat (gap) begin
            @(posedge clk);
            wrEn <= 1'b0;
        end
    endtask

    // wait for the builder to stop accepting, then throw junk at it
    task automatic endPass(input string test);
        int junk;
        @(posedge clk);
        wrEn <= 1'b0;
        waitReady(1'b0, test);
        if (aborted) begin
            return;
        end
        // scan is 16 cycles long, these all land while it runs
        repeat (3) begin
            drawBits(np, junk);
            @(posedge clk);
            sample <= np'(junk);
            wrEn   <= 1'b1;
        end
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    task automatic runMeasurement(input string test, input int expC, input int expL,
                                  input int expF);
        foreach (coarseSamples[i]) begin
            sendSample(coarseSamples[i], test);
            if (aborted) begin
                return;
            end
        end
        endPass(test);
        if (aborted) begin
            return;
        end
        foreach (fineSamples[i]) begin
            sendSample(fineSamples[i], test);
            if (aborted) begin
                return;
            end
        end
        endPass(test);
        if (aborted) begin
            return;
        end
        waitResult(test);
        if (aborted) begin
            return;
        end
        if (peakCoarse !== expC[nbLog2-1:0]) begin
            reportWrong(test, "peakCoarse", expC, peakCoarse);
        end
        if (windowLow !== expL[np-1:0]) begin
            reportWrong(test, "windowLow", expL, windowLow);
        end
        if (peakFine !== expF[nbLog2-1:0]) begin
            reportWrong(test, "peakFine", expF, peakFine);
        end
        // back to the coarse pass, ready again
        @(negedge clk);
        if (acqReady !== 1'b1) begin
            reportWrong(test, "acqReady after result", 1, acqReady);
        end
    endtask

    initial begin : mainFlow
        int    fd;
        int    code;
        int    value;
        int    lines;
        int    assertFails;
        bit    bad;
        string name;
        string rest;
        int    fileVals [3];
        int    calcVals [3];
        string fields [3];

        sample      = '0;
        wrEn        = 1'b0;
        lfsrState   = lfsrSeed;
        valueErrors = 0;
        traceErrors = 0;
        timeouts    = 0;
        aborted     = 1'b0;
        lines       = 0;
        fields      = '{"peakCoarse", "windowLow", "peakFine"};

        fd = $fopen(traceFile, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", traceFile);
            aborted = 1'b1;
        end
        if (!aborted) begin
            waitReset();
        end
        // reset state
        if (!aborted) begin
            if (acqReady !== 1'b1) reportWrong("reset", "acqReady", 1, acqReady);
            if (peakCoarse !== '0) reportWrong("reset", "peakCoarse", 0, peakCoarse);
            if (peakFine !== '0) reportWrong("reset", "peakFine", 0, peakFine);
            if (windowLow !== '0) reportWrong("reset", "windowLow", 0, windowLow);
        end

        // one measurement per trace line, no reset in between
        while (!aborted) begin
            code = $fscanf(fd, "%s", name);
            if (code != 1) begin
                break;
            end
            if (name[0] == "#") begin
                code = $fgets(rest, fd);
                continue;
            end
            bad = 1'b0;
            for (int i = 0; i < acqLen; i++) begin
                code = $fscanf(fd, "%h", value);
                if (code != 1) bad = 1'b1;
                coarseSamples[i] = np'(value);
            end
            for (int i = 0; i < acqLen; i++) begin
                code = $fscanf(fd, "%h", value);
                if (code != 1) bad = 1'b1;
                fineSamples[i] = np'(value);
            end
            for (int i = 0; i < 3; i++) begin
                code = $fscanf(fd, "%h", fileVals[i]);
                if (code != 1) bad = 1'b1;
            end
            if (bad) begin
                $display("trace line %s is missing fields", name);
                traceErrors++;
                aborted = 1'b1;
                break;
            end
            predict(calcVals[0], calcVals[1], calcVals[2]);
            for (int i = 0; i < 3; i++) begin
                if (fileVals[i] != calcVals[i]) begin
                    $display("trace line %s lists %s %0h but its samples give %0h",
                             name, fields[i], fileVals[i], calcVals[i]);
                    traceErrors++;
                end
            end
            runMeasurement(name, calcVals[0], calcVals[1], calcVals[2]);
            lines++;
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (!aborted && lines == 0) begin
            $display("the trace file holds no measurements");
            traceErrors++;
        end

        assertFails = dut0.checks0.fails;
        $display("%0d measurements, errors: %0d value, %0d trace, %0d timeout, %0d assertion",
                 lines, valueErrors, traceErrors, timeouts, assertFails);
        if (!aborted && valueErrors + traceErrors + timeouts + assertFails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : sifhTb

`default_nettype wire

// ==== test/sifhTrace.txt ====
# name, 8 coarse samples, 8 fine samples (hex)
# then expected peakCoarse, windowLow, peakFine (hex)
basic       52 57 5a 5c 31 a0 5f 21  50 51 52 50 60 48 30 51  5 48 4
tieCoarse   30 35 90 95 3f 9f c0 c1  2a 2b 40 41 46 80 00 47  3 28 1
clampLow    00 05 0f 0a 80 81 f0 11  00 01 1f 1e 1e 20 ff 10  0 00 f
clampHigh   f0 f5 ff fa 00 10 f8 e0  e0 e3 ff fe ef ee ed df  f e0 7
nearTop     e0 e1 e2 11 22 e5 f0 f1  f7 f6 d8 f8 ff e8 e9 ea  e d8 8
fineAllOut  70 71 72 73 74 75 76 77  00 10 20 30 40 a0 c0 ff  7 68 0
binOne      10 18 1f 12 44 55 66 77  08 27 26 25 07 28 10 11  1 08 4
spread      0a 1a 2a 3a 4a 5a 6a 7a  03 1c 1d 02 1c 40 21 0f  0 00 e
midRange    a0 a8 b0 b8 a3 c0 a4 12  b7 b6 b5 b4 a0 98 97 b8  a 98 e
basicAgain  52 57 5a 5c 31 a0 5f 21  50 51 52 50 60 48 30 51  5 48 4

// ==== files.f ====
hw/sifhPkg.sv
hw/dataFilter.sv
hw/histBuilder.sv
hw/peakDetector.sv
hw/sifhTop.sv
test/sifhClockGen.sv
test/sifhTop_assertions.sv
test/sifhTb.sv

// ==== Bender.yml ====
package:
  name: sifh

sources:
  - hw/sifhPkg.sv
  - hw/dataFilter.sv
  - hw/histBuilder.sv
  - hw/peakDetector.sv
  - hw/sifhTop.sv
  - target: test
    files:
      - test/sifhClockGen.sv
      - test/sifhTop_assertions.sv
      - test/sifhTb.sv
